// ==== ex_stage.f ====
common/ex_pkg.sv
src/int_alu.sv
src/branch_resolve.sv
muldiv/mul_pipe.sv
muldiv/iter_divider.sv
muldiv/muldiv_ctrl.sv
src/ex_stage.sv
tests/ex_stage_chk.sv
tests/tb_ex_stage.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_ex_stage
FILELIST   := ex_stage.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_ex_stage.sv ====
module tb_ex_stage;
    import ex_pkg::*;

    localparam int    MODE_NORMAL = 0;
    localparam int    MODE_ABORT  = 1;
    localparam int    MODE_CLEAR  = 2;
    localparam addr_t ALU_PC      = 32'h0000_1000;
    localparam addr_t BR_PC       = 32'h0000_2000;

    typedef struct {
        alu_op_e   op;
        word_t     a;
        word_t     b;
        word_t     imm;
        addr_t     pc;
        logic      ptaken;
        addr_t     ptgt;
        reg_addr_t waddr;
        logic      we;
        word_t     exp_wdata;
        logic      exp_redir;
        addr_t     exp_tgt;
        int        mode;
    } row_t;

    logic      clk;
    logic      rst;
    logic      flush;
    logic      clear;
    logic      advance;
    alu_op_e   op;
    word_t     opnd1;
    word_t     opnd2;
    word_t     imm;
    addr_t     pc;
    addr_t     pred_target;
    reg_addr_t waddr;
    logic      we;
    logic      pred_taken;
    logic      ready;
    logic      redirect;
    addr_t     redirect_target;
    logic      wb_valid;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    row_t rows[$];
    int   cur_row;
    int   checks;
    int   errors;
    bit   table_built;

    ex_stage dut_i (
        .clk               (clk),
        .rst               (rst),
        .flush_i           (flush),
        .clear_i           (clear),
        .advance_i         (advance),
        .op_i              (op),
        .opnd1_i           (opnd1),
        .opnd2_i           (opnd2),
        .imm_i             (imm),
        .pc_i              (pc),
        .pred_target_i     (pred_target),
        .waddr_i           (waddr),
        .we_i              (we),
        .pred_taken_i      (pred_taken),
        .ready_o           (ready),
        .redirect_o        (redirect),
        .redirect_target_o (redirect_target),
        .wb_valid_o        (wb_valid),
        .wb_we_o           (wb_we),
        .wb_waddr_o        (wb_waddr),
        .wb_wdata_o        (wb_wdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    //////////////////////////////
    // Compare tasks

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s row %0d: got %08h, expected %08h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s row %0d: got %08h, expected %08h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s row %0d: got %02h, expected %02h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s row %0d: got %0h, expected %0h", name, cur_row, got, exp);
        end
    endtask

    //////////////////////////////
    // Table construction

    task automatic add_row(alu_op_e r_op, word_t a, word_t b, word_t r_imm, addr_t r_pc,
                           logic ptaken, addr_t ptgt, logic r_we, word_t exp_wdata,
                           logic exp_redir, addr_t exp_tgt, int mode);
        row_t r;
        r.op        = r_op;
        r.a         = a;
        r.b         = b;
        r.imm       = r_imm;
        r.pc        = r_pc;
        r.ptaken    = ptaken;
        r.ptgt      = ptgt;
        r.waddr     = reg_addr_t'(rows.size() % 31 + 1);
        r.we        = r_we;
        r.exp_wdata = exp_wdata;
        r.exp_redir = exp_redir;
        r.exp_tgt   = exp_tgt;
        r.mode      = mode;
        rows.push_back(r);
    endtask

    task automatic add_alu(alu_op_e r_op, word_t a, word_t b, word_t exp, int mode);
        add_row(r_op, a, b, '0, ALU_PC, 1'b0, '0, 1'b1, exp, 1'b0, '0, mode);
    endtask

    // Link ops write the return address
    task automatic add_branch(alu_op_e r_op, word_t a, word_t b, word_t r_imm, logic ptaken,
                              addr_t ptgt, logic exp_redir, addr_t exp_tgt);
        logic link;
        link = r_op inside {BL, JIRL};
        add_row(r_op, a, b, r_imm, BR_PC, ptaken, ptgt, link, BR_PC + 32'd4,
                exp_redir, exp_tgt, MODE_NORMAL);
    endtask

    function automatic word_t mul_expect(alu_op_e r_op, word_t a, word_t b);
        longint sa;
        longint sb;
        logic [63:0] prod;
        if (r_op == MULHU) begin
            prod = {32'h0, a} * {32'h0, b};
        end else begin
            sa   = longint'($signed(a));
            sb   = longint'($signed(b));
            prod = 64'(sa * sb);
        end
        return (r_op == MUL) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic build_table();
        word_t ra;
        word_t rb;
        add_alu(ADD,   32'h0000_0005, 32'h0000_0007, 32'h0000_000c, MODE_NORMAL);
        add_alu(SUB,   32'h0000_0003, 32'h0000_0005, 32'hffff_fffe, MODE_NORMAL);
        add_alu(SLT,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, MODE_NORMAL);
        add_alu(SLTU,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, MODE_NORMAL);
        add_alu(SLT,   32'h0000_0001, 32'hffff_ffff, 32'h0000_0000, MODE_NORMAL);
        add_alu(SLTU,  32'h0000_0001, 32'hffff_ffff, 32'h0000_0001, MODE_NORMAL);
        add_alu(AND,   32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, MODE_NORMAL);
        add_alu(OR,    32'hf0f0_f0f0, 32'hff00_ff00, 32'hfff0_fff0, MODE_NORMAL);
        add_alu(XOR,   32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0, MODE_NORMAL);
        add_alu(NOR,   32'hf0f0_f0f0, 32'hff00_ff00, 32'h000f_000f, MODE_NORMAL);
        add_alu(SLL,   32'h0000_0001, 32'h0000_0004, 32'h0000_0010, MODE_NORMAL);
        add_alu(SRL,   32'h8000_0000, 32'h0000_0004, 32'h0800_0000, MODE_NORMAL);
        add_alu(SRA,   32'h8000_0000, 32'h0000_0004, 32'hf800_0000, MODE_NORMAL);
        add_alu(LUI,   32'h0000_0000, 32'h1234_5000, 32'h1234_5000, MODE_NORMAL);
        add_alu(PCADD, 32'h0000_0000, 32'h0000_2000, 32'h0000_3000, MODE_NORMAL);
        // Products from a 64-bit reference
        add_alu(MUL,   32'h0000_0007, 32'hffff_fffd,
                mul_expect(MUL, 32'h0000_0007, 32'hffff_fffd), MODE_NORMAL);
        add_alu(MULH,  32'h8000_0000, 32'h0000_0002,
                mul_expect(MULH, 32'h8000_0000, 32'h0000_0002), MODE_NORMAL);
        add_alu(MULHU, 32'h8000_0000, 32'h0000_0002,
                mul_expect(MULHU, 32'h8000_0000, 32'h0000_0002), MODE_NORMAL);
        add_alu(MULH,  32'hffff_ffff, 32'hffff_ffff,
                mul_expect(MULH, 32'hffff_ffff, 32'hffff_ffff), MODE_NORMAL);
        add_alu(MULHU, 32'hffff_ffff, 32'hffff_ffff,
                mul_expect(MULHU, 32'hffff_ffff, 32'hffff_ffff), MODE_NORMAL);
        add_alu(DIV,   32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd, MODE_NORMAL);
        add_alu(MOD,   32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff, MODE_NORMAL);
        add_alu(DIV,   32'h0000_0007, 32'hffff_fffe, 32'hffff_fffd, MODE_NORMAL);
        add_alu(MOD,   32'h0000_0007, 32'hffff_fffe, 32'h0000_0001, MODE_NORMAL);
        add_alu(DIVU,  32'hffff_fff9, 32'h0000_0002, 32'h7fff_fffc, MODE_NORMAL);
        add_alu(MODU,  32'hffff_fff9, 32'h0000_0002, 32'h0000_0001, MODE_NORMAL);
        // Zero divisor gives the dividend and zero
        add_alu(DIV,   32'h1234_5678, 32'h0000_0000, 32'h1234_5678, MODE_NORMAL);
        add_alu(MOD,   32'h1234_5678, 32'h0000_0000, 32'h0000_0000, MODE_NORMAL);
        add_alu(DIVU,  32'h8000_0000, 32'h0000_0000, 32'h8000_0000, MODE_NORMAL);
        add_branch(BEQ,  32'h5, 32'h5, 32'h100, 1'b1, 32'h2100, 1'b0, '0);
        add_branch(BNE,  32'h5, 32'h5, 32'h100, 1'b0, '0, 1'b0, '0);
        add_branch(BLT,  32'hffff_ffff, 32'h1, 32'h100, 1'b0, '0, 1'b1, 32'h2100);
        add_branch(BLTU, 32'hffff_ffff, 32'h1, 32'h100, 1'b1, 32'h2100, 1'b1, 32'h2004);
        add_branch(BGE,  32'h1, 32'hffff_ffff, 32'h100, 1'b1, 32'h2200, 1'b1, 32'h2100);
        add_branch(BGEU, 32'h1, 32'hffff_ffff, 32'h100, 1'b0, '0, 1'b0, '0);
        add_branch(B,    32'h0, 32'h0, 32'h100, 1'b1, 32'h2100, 1'b0, '0);
        add_branch(BL,   32'h0, 32'h0, 32'h100, 1'b0, '0, 1'b1, 32'h2100);
        add_branch(JIRL, 32'h4000, 32'h0, 32'h10, 1'b1, 32'h4010, 1'b0, '0);
        add_branch(JIRL, 32'h4000, 32'h0, 32'h10, 1'b1, 32'h4000, 1'b1, 32'h4010);
        add_alu(DIV,   32'd100, 32'd7, 32'd14, MODE_ABORT);
        add_alu(ADD,   32'd2, 32'd3, 32'd5, MODE_NORMAL);
        add_alu(DIV,   32'd100, 32'd7, 32'd14, MODE_NORMAL);
        add_alu(MOD,   32'd100, 32'd7, 32'd2, MODE_NORMAL);
        add_alu(ADD,   32'd1, 32'd1, 32'd2, MODE_CLEAR);
        for (int k = 0; k < 6; k++) begin
            ra = $urandom;
            rb = $urandom;
            case (k % 3)
                0:       add_alu(ADD, ra, rb, ra + rb, MODE_NORMAL);
                1:       add_alu(SUB, ra, rb, ra - rb, MODE_NORMAL);
                default: add_alu(XOR, ra, rb, ra ^ rb, MODE_NORMAL);
            endcase
        end
    endtask

    //////////////////////////////
    // Row sequencing

    task automatic abort_divide();
        repeat (5) begin
            @(negedge clk);
            check_bit("ready_o", ready, 1'b0);
            check_bit("wb_valid_o", wb_valid, 1'b0);
        end
        @(posedge clk);
        #2 flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        // The flushed divide is gone from dispatch
        op    = NOP;
        @(negedge clk);
        check_bit("wb_valid_o", wb_valid, 1'b0);
    endtask

    task automatic apply_row(row_t r);
        @(posedge clk);
        #2;
        op          = r.op;
        opnd1       = r.a;
        opnd2       = r.b;
        imm         = r.imm;
        pc          = r.pc;
        pred_taken  = r.ptaken;
        pred_target = r.ptgt;
        waddr       = r.waddr;
        we          = r.we;
        if (r.mode == MODE_ABORT) begin
            abort_divide();
        end else begin
            // Nothing may be written back while the stage stalls
            @(negedge clk);
            while (!ready) begin
                check_bit("wb_valid_o", wb_valid, 1'b0);
                @(negedge clk);
            end
            @(posedge clk);
            #2;
            advance = 1'b1;
            clear   = (r.mode == MODE_CLEAR);
            @(negedge clk);
            check_bit("redirect_o", redirect, r.exp_redir);
            if (r.exp_redir) begin
                check_addr("redirect_target_o", redirect_target, r.exp_tgt);
            end
            @(posedge clk);
            #2;
            advance = 1'b0;
            clear   = 1'b0;
            // Bubble until the next row
            op      = NOP;
            @(negedge clk);
            if (r.mode == MODE_CLEAR) begin
                check_bit("wb_valid_o", wb_valid, 1'b0);
                check_bit("wb_we_o", wb_we, 1'b0);
            end else begin
                check_bit("wb_valid_o", wb_valid, 1'b1);
                check_bit("wb_we_o", wb_we, r.we);
                check_reg("wb_waddr_o", wb_waddr, r.waddr);
                if (r.we) begin
                    check_word("wb_wdata_o", wb_wdata, r.exp_wdata);
                end
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        flush       = 1'b0;
        clear       = 1'b0;
        advance     = 1'b0;
        op          = NOP;
        opnd1       = '0;
        opnd2       = '0;
        imm         = '0;
        pc          = '0;
        pred_target = '0;
        waddr       = '0;
        we          = 1'b0;
        pred_taken  = 1'b0;
        cur_row     = 0;
        checks      = 0;
        errors      = 0;
        table_built = 1'b0;
        void'($urandom(32'h96b1e532));
        build_table();
        table_built = 1'b1;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            cur_row = i;
            apply_row(rows[i]);
        end
        $display("Checks: %0d run, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_built);
        repeat (rows.size() * (DIV_CYCLES + 8)) @(posedge clk);
        $display("Timeout: the stage stopped making progress at row %0d", cur_row);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== tests/ex_stage_chk.sv ====
module ex_stage_chk (
    input logic            clk,
    input logic            rst,
    input logic            advance_i,
    input logic            flush_i,
    input logic            clear_i,
    input ex_pkg::alu_op_e op_i,
    input logic            ready_i,
    input logic            redirect_i,
    input logic            wb_valid_i
);
    import ex_pkg::*;

    redirect_needs_advance: assert property (
        @(posedge clk) disable iff (rst) redirect_i |-> advance_i
    ) else $error("redirect_o high without advance_i");

    // Write-back follows a clean advance
    wb_valid_after_advance: assert property (
        @(posedge clk) disable iff (rst)
        wb_valid_i |-> $past(advance_i && !flush_i && !clear_i)
    ) else $error("wb_valid_o high without a clean advance in the previous cycle");

    ready_for_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        !(op_i inside {MUL, MULH, MULHU, DIV, DIVU, MOD, MODU}) |-> ready_i
    ) else $error("ready_o low for a single-cycle operation");

endmodule

bind ex_stage ex_stage_chk u_ex_stage_chk (
    .clk        (clk),
    .rst        (rst),
    .advance_i  (advance_i),
    .flush_i    (flush_i),
    .clear_i    (clear_i),
    .op_i       (op_i),
    .ready_i    (ready_o),
    .redirect_i (redirect_o),
    .wb_valid_i (wb_valid_o)
);

// ==== src/ex_stage.sv ====
module ex_stage (
    input  logic              clk,
    input  logic              rst,

    input  logic              flush_i,
    input  logic              clear_i,
    input  logic              advance_i,

    input  ex_pkg::alu_op_e   op_i,
    input  ex_pkg::word_t     opnd1_i,
    input  ex_pkg::word_t     opnd2_i,
    input  ex_pkg::word_t     imm_i,
    input  ex_pkg::addr_t     pc_i,
    input  ex_pkg::addr_t     pred_target_i,
    input  ex_pkg::reg_addr_t waddr_i,
    input  logic              we_i,
    input  logic              pred_taken_i,

    output logic              ready_o,
    output logic              redirect_o,
    output ex_pkg::addr_t     redirect_target_o,

    output logic              wb_valid_o,
    output logic              wb_we_o,
    output ex_pkg::reg_addr_t wb_waddr_o,
    output ex_pkg::word_t     wb_wdata_o
);
    import ex_pkg::*;

    word_t      alu_result;
    word_t      md_result;
    word_t      wdata;
    logic       md_ready;
    logic       mispredict;
    addr_t      br_target;

    int_alu u_int_alu (
        .op_i     (op_i),
        .opnd1_i  (opnd1_i),
        .opnd2_i  (opnd2_i),
        .pc_i     (pc_i),
        .result_o (alu_result)
    );

    branch_resolve u_branch_resolve (
        .op_i          (op_i),
        .opnd1_i       (opnd1_i),
        .opnd2_i       (opnd2_i),
        .imm_i         (imm_i),
        .pc_i          (pc_i),
        .pred_target_i (pred_target_i),
        .pred_taken_i  (pred_taken_i),
        .mispredict_o  (mispredict),
        .target_o      (br_target)
    );

    muldiv_ctrl u_muldiv_ctrl (
        .clk       (clk),
        .rst       (rst),
        .flush_i   (flush_i),
        .advance_i (advance_i),
        .op_i      (op_i),
        .opnd1_i   (opnd1_i),
        .opnd2_i   (opnd2_i),
        .ready_o   (md_ready),
        .result_o  (md_result)
    );

    assign ready_o = md_ready;

    // Redirect only counts once the instruction leaves
    assign redirect_o        = mispredict & advance_i;
    assign redirect_target_o = br_target;

    assign wdata = (res_class_of(op_i) == MULDIV) ? md_result : alu_result;

    //////////////////////////////
    // Result register

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else if (flush_i | clear_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            wb_valid_o <= advance_i;
            wb_we_o    <= advance_i & we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            wb_waddr_o <= waddr_i;
            wb_wdata_o <= wdata;
        end
    end

endmodule

// ==== muldiv/muldiv_ctrl.sv ====
module muldiv_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            advance_i,
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   opnd1_i,
    input  ex_pkg::word_t   opnd2_i,
    output logic            ready_o,
    output ex_pkg::word_t   result_o
);
    import ex_pkg::*;

    logic  is_mul;
    logic  is_div;
    logic  mul_start;
    logic  div_start;
    logic  mul_started;
    logic  div_started;
    logic  finished;
    logic  finish_now;
    logic  mul_done;
    logic  div_done;
    logic  div_busy;
    word_t mul_res;
    word_t quotient;
    word_t remainder;
    word_t divisor;
    word_t res_now;
    word_t res_q;

    assign is_mul = is_mul_op(op_i);
    assign is_div = is_div_op(op_i);

    //////////////////////////////
    // Start bookkeeping

    assign mul_start = is_mul & ~mul_started & ~finished & ~flush_i;
    // An aborted divide may still be running
    assign div_start = is_div & ~div_started & ~finished & ~flush_i & ~div_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_started <= 1'b0;
            div_started <= 1'b0;
        end else if (advance_i | flush_i) begin
            mul_started <= 1'b0;
            div_started <= 1'b0;
        end else begin
            if (mul_start) mul_started <= 1'b1;
            if (div_start) div_started <= 1'b1;
        end
    end

    // Done pulses of aborted operations are ignored
    assign finish_now = (mul_done & mul_started) | (div_done & div_started);

    always_ff @(posedge clk) begin
        if (rst) begin
            finished <= 1'b0;
        end else if (advance_i | flush_i) begin
            finished <= 1'b0;
        end else if (finish_now) begin
            finished <= 1'b1;
        end
    end

    always_comb begin
        if (is_mul) begin
            res_now = mul_res;
        end else if (op_i inside {DIV, DIVU}) begin
            res_now = quotient;
        end else begin
            res_now = remainder;
        end
    end

    always_ff @(posedge clk) begin
        if (finish_now) begin
            res_q <= res_now;
        end
    end

    assign ready_o  = ~(is_mul | is_div) | finished | finish_now;
    assign result_o = finish_now ? res_now : res_q;

    // Zero divisor runs as divide by one
    assign divisor = (opnd2_i == '0) ? word_t'(1) : opnd2_i;

    mul_pipe u_mul_pipe (
        .clk      (clk),
        .rst      (rst),
        .start_i  (mul_start),
        .a_i      (opnd1_i),
        .b_i      (opnd2_i),
        .signed_i (op_i != MULHU),
        .high_i   (op_i != MUL),
        .done_o   (mul_done),
        .result_o (mul_res)
    );

    iter_divider u_iter_divider (
        .clk         (clk),
        .rst         (rst),
        .start_i     (div_start),
        .signed_i    (op_i inside {DIV, MOD}),
        .dividend_i  (opnd1_i),
        .divisor_i   (divisor),
        .busy_o      (div_busy),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

endmodule

// ==== muldiv/iter_divider.sv ====
module iter_divider (
    input  logic          clk,
    input  logic          rst,
    input  logic          start_i,
    input  logic          signed_i,
    input  ex_pkg::word_t dividend_i,
    input  ex_pkg::word_t divisor_i,
    output logic          busy_o,
    output logic          done_o,
    output ex_pkg::word_t quotient_o,
    output ex_pkg::word_t remainder_o
);
    import ex_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIXUP
    } div_state_e;

    div_state_e                    state;
    logic [$clog2(DIV_CYCLES)-1:0] cnt;
    word_t                         dvs_mag;
    word_t                         quo_mag;
    word_t                         rem_mag;
    logic                          neg_q;
    logic                          neg_r;
    logic [XLEN:0]                 partial;
    logic [XLEN:0]                 trial;

    // Shift in next dividend bit and try to subtract
    assign partial = {rem_mag, quo_mag[XLEN-1]};
    assign trial   = partial - {1'b0, dvs_mag};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state <= RUN;
                        cnt   <= '0;
                    end
                end
                RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == $bits(cnt)'(DIV_CYCLES - 1)) begin
                        state <= FIXUP;
                    end
                end
                FIXUP:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            quo_mag <= (signed_i & dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
            dvs_mag <= (signed_i & divisor_i[XLEN-1]) ? -divisor_i : divisor_i;
            rem_mag <= '0;
            neg_q   <= signed_i & (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
            neg_r   <= signed_i & dividend_i[XLEN-1];
        end else if (state == RUN) begin
            // Restore on negative trial
            if (!trial[XLEN]) begin
                rem_mag <= trial[XLEN-1:0];
            end else begin
                rem_mag <= partial[XLEN-1:0];
            end
            quo_mag <= {quo_mag[XLEN-2:0], ~trial[XLEN]};
        end
    end

    assign busy_o = state != IDLE;
    assign done_o = state == FIXUP;

    // Sign fixup on the magnitudes
    assign quotient_o  = neg_q ? -quo_mag : quo_mag;
    assign remainder_o = neg_r ? -rem_mag : rem_mag;

endmodule

// ==== muldiv/mul_pipe.sv ====
module mul_pipe (
    input  logic          clk,
    input  logic          rst,
    input  logic          start_i,
    input  ex_pkg::word_t a_i,
    input  ex_pkg::word_t b_i,
    input  logic          signed_i,
    input  logic          high_i,
    output logic          done_o,
    output ex_pkg::word_t result_o
);
    import ex_pkg::*;

    logic [MUL_STAGES-1:0]   vld;
    logic signed [XLEN:0]    a_s1;
    logic signed [XLEN:0]    b_s1;
    logic                    high_s1;
    logic                    high_s2;
    logic [2*XLEN-1:0]       prod_s2;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[MUL_STAGES-2:0], start_i};
        end
    end

    // Stage 1, operands extended by one sign bit
    always_ff @(posedge clk) begin
        a_s1    <= {signed_i & a_i[XLEN-1], a_i};
        b_s1    <= {signed_i & b_i[XLEN-1], b_i};
        high_s1 <= high_i;
    end

    // Stage 2
    always_ff @(posedge clk) begin
        prod_s2 <= (2*XLEN)'(a_s1) * (2*XLEN)'(b_s1);
        high_s2 <= high_s1;
    end

    assign done_o   = vld[MUL_STAGES-1];
    assign result_o = high_s2 ? prod_s2[2*XLEN-1:XLEN] : prod_s2[XLEN-1:0];

endmodule

// ==== src/branch_resolve.sv ====
module branch_resolve (
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   opnd1_i,
    input  ex_pkg::word_t   opnd2_i,
    input  ex_pkg::word_t   imm_i,
    input  ex_pkg::addr_t   pc_i,
    input  ex_pkg::addr_t   pred_target_i,
    input  logic            pred_taken_i,
    output logic            mispredict_o,
    output ex_pkg::addr_t   target_o
);
    import ex_pkg::*;

    logic  taken;
    logic  dir_miss;
    logic  tgt_miss;
    addr_t jump_target;
    addr_t fall_through;

    always_comb begin
        case (op_i)
            BEQ:          taken = opnd1_i == opnd2_i;
            BNE:          taken = opnd1_i != opnd2_i;
            BLT:          taken = $signed(opnd1_i) < $signed(opnd2_i);
            BGE:          taken = $signed(opnd1_i) >= $signed(opnd2_i);
            BLTU:         taken = opnd1_i < opnd2_i;
            BGEU:         taken = opnd1_i >= opnd2_i;
            B, BL, JIRL:  taken = 1'b1;
            default:      taken = 1'b0;
        endcase
    end

    // JIRL jumps register relative, the rest pc relative
    assign jump_target  = (op_i == JIRL) ? opnd1_i + imm_i : pc_i + imm_i;
    assign fall_through = pc_i + addr_t'(INSTR_BYTES);

    assign dir_miss = taken ^ pred_taken_i;
    assign tgt_miss = taken & pred_taken_i & (jump_target != pred_target_i);

    assign mispredict_o = dir_miss | tgt_miss;
    assign target_o     = taken ? jump_target : fall_through;

endmodule

// ==== src/int_alu.sv ====
module int_alu (
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   opnd1_i,
    input  ex_pkg::word_t   opnd2_i,
    input  ex_pkg::addr_t   pc_i,
    output ex_pkg::word_t   result_o
);
    import ex_pkg::*;

    word_t       logic_res;
    word_t       shift_res;
    word_t       move_res;
    word_t       arith_res;
    word_t       link_res;
    word_t       opnd2_neg;
    word_t       diff;
    logic        lt_signed;
    logic        lt_unsigned;
    logic [4:0]  shamt;

    // opnd1 - opnd2, shared by SUB and SLT
    assign opnd2_neg = ~opnd2_i + word_t'(1);
    assign diff      = opnd1_i + opnd2_neg;

    // Signed compare by sign cases
    assign lt_signed = (opnd1_i[XLEN-1] & ~opnd2_i[XLEN-1])
                     | (~opnd1_i[XLEN-1] & ~opnd2_i[XLEN-1] & diff[XLEN-1])
                     | (opnd1_i[XLEN-1] & opnd2_i[XLEN-1] & diff[XLEN-1]);
    assign lt_unsigned = opnd1_i < opnd2_i;

    assign shamt = opnd2_i[4:0];

    always_comb begin
        case (op_i)
            AND:     logic_res = opnd1_i & opnd2_i;
            OR:      logic_res = opnd1_i | opnd2_i;
            XOR:     logic_res = opnd1_i ^ opnd2_i;
            NOR:     logic_res = ~(opnd1_i | opnd2_i);
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            SLL:     shift_res = opnd1_i << shamt;
            SRL:     shift_res = opnd1_i >> shamt;
            SRA:     shift_res = word_t'($signed(opnd1_i) >>> shamt);
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            LUI:     move_res = opnd2_i;
            PCADD:   move_res = pc_i + opnd2_i;
            default: move_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            ADD:     arith_res = opnd1_i + opnd2_i;
            SUB:     arith_res = diff;
            SLT:     arith_res = {{(XLEN-1){1'b0}}, lt_signed};
            SLTU:    arith_res = {{(XLEN-1){1'b0}}, lt_unsigned};
            default: arith_res = '0;
        endcase
    end

    // Return address for BL and JIRL
    assign link_res = pc_i + addr_t'(INSTR_BYTES);

    always_comb begin
        case (res_class_of(op_i))
            LOGIC:   result_o = logic_res;
            SHIFT:   result_o = shift_res;
            MOVE:    result_o = move_res;
            ARITH:   result_o = arith_res;
            LINK:    result_o = link_res;
            default: result_o = '0;
        endcase
    end

endmodule

// ==== common/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN        = 32;
    localparam int DIV_CYCLES  = 32;
    localparam int MUL_STAGES  = 2;
    localparam int INSTR_BYTES = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     addr_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [4:0] {
        ADD, SUB, SLT, SLTU,
        AND, OR, XOR, NOR,
        SLL, SRL, SRA,
        LUI, PCADD,
        MUL, MULH, MULHU,
        DIV, DIVU, MOD, MODU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU, B, BL, JIRL,
        NOP
    } alu_op_e;

    typedef enum logic [2:0] {
        LOGIC,
        SHIFT,
        MOVE,
        ARITH,
        LINK,
        MULDIV,
        NONE
    } res_class_e;

    // Which result path feeds the write data
    function automatic res_class_e res_class_of(alu_op_e op);
        res_class_e rc;
        case (op)
            AND, OR, XOR, NOR:           rc = LOGIC;
            SLL, SRL, SRA:               rc = SHIFT;
            LUI, PCADD:                  rc = MOVE;
            ADD, SUB, SLT, SLTU:         rc = ARITH;
            BL, JIRL:                    rc = LINK;
            MUL, MULH, MULHU:            rc = MULDIV;
            DIV, DIVU, MOD, MODU:        rc = MULDIV;
            default:                     rc = NONE;
        endcase
        return rc;
    endfunction

    function automatic logic is_mul_op(alu_op_e op);
        return op inside {MUL, MULH, MULHU};
    endfunction

    function automatic logic is_div_op(alu_op_e op);
        return op inside {DIV, DIVU, MOD, MODU};
    endfunction

endpackage
